// File: source/byp_pkg.sv
`default_nettype none

package byp_pkg;

   ////////////////////////////////////////
   // datapath widths
   ////////////////////////////////////////
   localparam int DATA_W = 64;
   localparam int CHK_W  = 8;             // one even-parity bit per byte
   localparam int PC_W   = 48;
   localparam int IMM_W  = 32;
   localparam int Y_W    = 32;
   localparam int PR_W   = 8;

   typedef logic [DATA_W-1:0]       data_t;
   typedef logic [CHK_W+DATA_W-1:0] rf_word_t;  // check bits sit above data
   typedef logic [PC_W-1:0]         pc_t;
   typedef logic [IMM_W-1:0]        imm_t;

   ////////////////////////////////////////
   // select encodings
   ////////////////////////////////////////
   // operand forwarding source, other is pc for rs1 and imm for rs2
   typedef enum logic [2:0] {
      BYP_RF, BYP_E, BYP_M, BYP_W, BYP_LD, BYP_OTHER
   } byp_src_e;

   typedef enum logic [1:0] {
      RD_YREG, RD_PR, RD_VER, RD_ALU
   } rd_src_e;

   typedef enum logic [1:0] {
      WB_PIPE, WB_LOAD, WB_RESTORE
   } wb_src_e;

endpackage

`default_nettype wire

// File: source/byp_operand_decode.sv
`timescale 1ns/1ps
`default_nettype none

module byp_operand_decode
   import byp_pkg::*;
(
   input  wire      clk,
   input  wire      rst_n,
   input  byp_src_e rs1_sel,
   input  byp_src_e rs2_sel,
   input  data_t    rf_rs1_data,
   input  data_t    rf_rs2_data,
   input  pc_t      pc_d,
   input  imm_t     imm_d,
   input  data_t    alu_rd_data_e,   // e stage result, not yet flopped
   input  data_t    rd_data_m,
   input  data_t    rd_data_w,
   input  data_t    load_data_g,     // raw fill data straight from lsu
   output data_t    rs1_data_e,
   output data_t    rs2_data_e
);

   data_t rs1_other_d;
   data_t rs2_other_d;
   data_t rs1_data_d;
   data_t rs2_data_d;

   // same forwarding network for both operands, only the other input differs
   function automatic data_t fwd_mux(byp_src_e sel, data_t rf, data_t other);
      case (sel)
         BYP_RF:    return rf;
         BYP_E:     return alu_rd_data_e;
         BYP_M:     return rd_data_m;
         BYP_W:     return rd_data_w;
         BYP_LD:    return load_data_g;
         BYP_OTHER: return other;
         default:   return rf;
      endcase
   endfunction

   assign rs1_other_d = {{(DATA_W-PC_W){pc_d[PC_W-1]}}, pc_d};      // sign-extended pc
   assign rs2_other_d = {{(DATA_W-IMM_W){imm_d[IMM_W-1]}}, imm_d};  // sign-extended imm

   always_comb begin
      rs1_data_d = fwd_mux(rs1_sel, rf_rs1_data, rs1_other_d);
      rs2_data_d = fwd_mux(rs2_sel, rf_rs2_data, rs2_other_d);
   end

   ////////////////////////////////////////
   // d-e operand registers
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rs1_data_e <= '0;
         rs2_data_e <= '0;
      end else begin
         rs1_data_e <= rs1_data_d;
         rs2_data_e <= rs2_data_d;
      end
   end

endmodule

`default_nettype wire

// File: source/byp_execute.sv
`timescale 1ns/1ps
`default_nettype none

module byp_execute
   import byp_pkg::*;
(
   input  wire              clk,
   input  wire              rst_n,
   input  byp_pkg::rd_src_e rd_src_e,
   input  logic [Y_W-1:0]   yreg_e,
   input  logic [PR_W-1:0]  pr_e,
   input  data_t            ver_e,          // version register, already 64 bits
   input  data_t            alu_rd_data_e,
   output data_t            rd_data_m,
   output data_t            wsr_data_m
);

   data_t rd_data_e;

   // rdsr/rdpr source select, narrow registers are zero-extended
   always_comb begin
      case (rd_src_e)
         RD_YREG: rd_data_e = {{(DATA_W-Y_W){1'b0}}, yreg_e};
         RD_PR:   rd_data_e = {{(DATA_W-PR_W){1'b0}}, pr_e};
         RD_VER:  rd_data_e = ver_e;
         default: rd_data_e = alu_rd_data_e;   // RD_ALU
      endcase
   end

   ////////////////////////////////////////
   // e-m result register
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_data_m <= '0;
      end else begin
         rd_data_m <= rd_data_e;
      end
   end

   // wrsr takes its operand from the m stage result
   assign wsr_data_m = rd_data_m;

endmodule

`default_nettype wire

// File: source/byp_result.sv
`timescale 1ns/1ps
`default_nettype none

module byp_result
   import byp_pkg::*;
(
   input  wire      clk,
   input  wire      rst_n,
   input  data_t    load_data_g,
   input  data_t    ldxa_data_g,     // alternate-space load return
   input  wire      ldxa_g,
   input  wire      restore_m,       // capture rd_data_m into the restore buffer
   input  wb_src_e  wb_sel_m,
   input  data_t    rd_data_m,
   output rf_word_t rd_word_w,
   output data_t    rd_data_w
);

   data_t            load_data_mux_g;
   data_t            load_data_g2;
   data_t            restore_data;
   data_t            wb_data_m;
   logic [CHK_W-1:0] wb_chk_m;

   // check bit i covers byte i, so each byte plus its bit has even parity
   function automatic logic [CHK_W-1:0] byte_parity(data_t d);
      logic [CHK_W-1:0] p;
      for (int i = 0; i < CHK_W; i++) begin
         p[i] = ^d[8*i +: 8];
      end
      return p;
   endfunction

   ////////////////////////////////////////
   // load return capture
   ////////////////////////////////////////
   assign load_data_mux_g = ldxa_g ? ldxa_data_g : load_data_g;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         load_data_g2 <= '0;
      end else begin
         load_data_g2 <= load_data_mux_g;
      end
   end

   // restore buffer holds until the next restore_m
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         restore_data <= '0;
      end else if (restore_m) begin
         restore_data <= rd_data_m;
      end
   end

   ////////////////////////////////////////
   // writeback select and m-w register
   ////////////////////////////////////////
   always_comb begin
      case (wb_sel_m)
         WB_LOAD:    wb_data_m = load_data_g2;
         WB_RESTORE: wb_data_m = restore_data;
         default:    wb_data_m = rd_data_m;      // WB_PIPE
      endcase
   end

   assign wb_chk_m = byte_parity(wb_data_m);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_word_w <= '0;
      end else begin
         rd_word_w <= {wb_chk_m, wb_data_m};
      end
   end

   assign rd_data_w = rd_word_w[DATA_W-1:0];   // w forwarding path, data only

endmodule

`default_nettype wire

// File: source/exu_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module exu_bypass
   import byp_pkg::*;
(
   input  wire              clk,
   input  wire              rst_n,
   // d stage operand inputs
   input  byp_src_e         rs1_sel,
   input  byp_src_e         rs2_sel,
   input  data_t            rf_rs1_data,
   input  data_t            rf_rs2_data,
   input  pc_t              pc_d,
   input  imm_t             imm_d,
   // e stage sources
   input  data_t            alu_rd_data_e,
   input  byp_pkg::rd_src_e rd_src_e,
   input  logic [Y_W-1:0]   yreg_e,
   input  logic [PR_W-1:0]  pr_e,
   input  data_t            ver_e,
   // load return and writeback control
   input  data_t            load_data_g,
   input  data_t            ldxa_data_g,
   input  wire              ldxa_g,
   input  wire              restore_m,
   input  wb_src_e          wb_sel_m,
   output data_t            rs1_data_e,
   output data_t            rs2_data_e,
   output data_t            wsr_data_m,
   output rf_word_t         rd_word_w
);

   data_t rd_data_m;   // m stage result, also forwarded to d
   data_t rd_data_w;

   byp_operand_decode u_operand_decode (
      .clk           (clk),
      .rst_n         (rst_n),
      .rs1_sel       (rs1_sel),
      .rs2_sel       (rs2_sel),
      .rf_rs1_data   (rf_rs1_data),
      .rf_rs2_data   (rf_rs2_data),
      .pc_d          (pc_d),
      .imm_d         (imm_d),
      .alu_rd_data_e (alu_rd_data_e),
      .rd_data_m     (rd_data_m),
      .rd_data_w     (rd_data_w),
      .load_data_g   (load_data_g),
      .rs1_data_e    (rs1_data_e),
      .rs2_data_e    (rs2_data_e)
   );

   byp_execute u_execute (
      .clk           (clk),
      .rst_n         (rst_n),
      .rd_src_e      (rd_src_e),
      .yreg_e        (yreg_e),
      .pr_e          (pr_e),
      .ver_e         (ver_e),
      .alu_rd_data_e (alu_rd_data_e),
      .rd_data_m     (rd_data_m),
      .wsr_data_m    (wsr_data_m)
   );

   byp_result u_result (
      .clk         (clk),
      .rst_n       (rst_n),
      .load_data_g (load_data_g),
      .ldxa_data_g (ldxa_data_g),
      .ldxa_g      (ldxa_g),
      .restore_m   (restore_m),
      .wb_sel_m    (wb_sel_m),
      .rd_data_m   (rd_data_m),
      .rd_word_w   (rd_word_w),
      .rd_data_w   (rd_data_w)
   );

endmodule

`default_nettype wire

// File: verif/exu_bypass_sva.sv
`timescale 1ns/1ps
`default_nettype none

module exu_bypass_sva
   import byp_pkg::*;
(
   input wire              clk,
   input wire              rst_n,
   input byp_src_e         rs1_sel,
   input data_t            rf_rs1_data,
   input data_t            rs1_data_e,
   input byp_pkg::rd_src_e rd_src_e,
   input data_t            wsr_data_m,
   input rf_word_t         rd_word_w
);

   function automatic logic [CHK_W-1:0] parity_bits(data_t d);
      logic [CHK_W-1:0] c;
      for (int i = 0; i < CHK_W; i++) begin
         c[i] = ($countones(d[8*i +: 8]) % 2) == 1;
      end
      return c;
   endfunction

   // check bits sit above the data word
   chk_bits_match: assert property (@(posedge clk) disable iff (!rst_n)
      rd_word_w[DATA_W +: CHK_W] == parity_bits(rd_word_w[DATA_W-1:0]))
      else $error("rd_word_w check bits differ from byte parity");

   rf_operand_passes: assert property (@(posedge clk) disable iff (!rst_n)
      (rs1_sel == BYP_RF) |=> (rs1_data_e == $past(rf_rs1_data)))
      else $error("rs1_data_e is not the register file word after BYP_RF");

   yreg_zero_ext: assert property (@(posedge clk) disable iff (!rst_n)
      (rd_src_e == RD_YREG) |=> (wsr_data_m[DATA_W-1:Y_W] == '0))   // y is 32 bits wide
      else $error("wsr_data_m upper half not zero after RD_YREG");

endmodule

bind exu_bypass exu_bypass_sva u_exu_bypass_sva (
   .clk         (clk),
   .rst_n       (rst_n),
   .rs1_sel     (rs1_sel),
   .rf_rs1_data (rf_rs1_data),
   .rs1_data_e  (rs1_data_e),
   .rd_src_e    (rd_src_e),
   .wsr_data_m  (wsr_data_m),
   .rd_word_w   (rd_word_w)
);

`default_nettype wire

// File: verif/tb_exu_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu_bypass
   import byp_pkg::*;
();

   logic             clk;
   logic             rst_n;
   byp_src_e         rs1_sel;
   byp_src_e         rs2_sel;
   data_t            rf_rs1_data;
   data_t            rf_rs2_data;
   pc_t              pc_d;
   imm_t             imm_d;
   data_t            alu_rd_data_e;
   byp_pkg::rd_src_e rd_src;
   logic [Y_W-1:0]   yreg_e;
   logic [PR_W-1:0]  pr_e;
   data_t            ver_e;
   data_t            load_data_g;
   data_t            ldxa_data_g;
   logic             ldxa_g;
   logic             restore_m;
   wb_src_e          wb_sel_m;
   data_t            rs1_data_e;
   data_t            rs2_data_e;
   data_t            wsr_data_m;
   rf_word_t         rd_word_w;

   integer seed;
   int     errors;
   int     errors_at_open;
   int     tests_run;
   int     tests_failed;
   data_t  pipe_q[$];   // alu values on their way to w

   exu_bypass u_exu_bypass (
      .*,
      .rd_src_e (rd_src)
   );

   always #2 clk = ~clk;   // 4 ns period

   initial begin
      clk   = 1'b0;
      rst_n = 1'b0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
   end

   ////////////////////////////////////////
   // expected value helpers
   ////////////////////////////////////////
   // bit i makes byte i plus its check bit even
   function automatic logic [CHK_W-1:0] even_chk(data_t d);
      logic [CHK_W-1:0] c;
      for (int i = 0; i < CHK_W; i++) begin
         c[i] = ($countones(d[8*i +: 8]) % 2) == 1;
      end
      return c;
   endfunction

   function automatic rf_word_t with_chk(data_t d);
      return {even_chk(d), d};
   endfunction

   task automatic rand_data(output data_t d);
      d = {$random(seed), $random(seed)};
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic check_word(input string name, input rf_word_t got, input rf_word_t exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic open_test();
      errors_at_open = errors;
      tests_run++;
   endtask

   task automatic close_test(input string name);
      if (errors == errors_at_open) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: failed with %0d errors", name, errors - errors_at_open);
         tests_failed++;
      end
   endtask

   task automatic wait_reset(output bit released);
      int n;
      n = 0;
      while (rst_n !== 1'b1 && n < 20) begin
         @(posedge clk);   // rst_n moves on the falling edge
         n++;
      end
      released = (rst_n === 1'b1);
      @(negedge clk);
   endtask

   ////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////
   // live sources during reset, every register must still read zero
   task automatic reset_values();
      data_t d;
      open_test();
      rand_data(d);
      rs1_sel       = BYP_RF;
      rs2_sel       = BYP_RF;
      rf_rs1_data   = d;
      rf_rs2_data   = ~d;
      rd_src        = RD_VER;
      ver_e         = d;
      alu_rd_data_e = d;
      repeat (2) @(negedge clk);
      if (rst_n !== 1'b0) begin
         $display("rst_n went high before the reset values were checked");
         errors++;
      end
      check_data("rs1_data_e", rs1_data_e, '0);
      check_data("rs2_data_e", rs2_data_e, '0);
      check_data("wsr_data_m", wsr_data_m, '0);
      check_word("rd_word_w", rd_word_w, '0);
      rf_rs1_data   = '0;
      rf_rs2_data   = '0;
      rd_src        = RD_YREG;
      ver_e         = '0;
      alu_rd_data_e = '0;
      close_test("reset");
   endtask

   task automatic rf_and_other();
      data_t a;
      data_t b;
      open_test();
      rand_data(a);
      rand_data(b);
      rs1_sel     = BYP_RF;
      rs2_sel     = BYP_RF;
      rf_rs1_data = a;
      rf_rs2_data = b;
      @(negedge clk);
      check_data("rs1_data_e", rs1_data_e, a);
      check_data("rs2_data_e", rs2_data_e, b);
      // negative pc and imm first
      rs1_sel = BYP_OTHER;
      rs2_sel = BYP_OTHER;
      pc_d    = 48'h8000_1234_5678;
      imm_d   = 32'hffff_fff0;
      @(negedge clk);
      check_data("rs1_data_e", rs1_data_e, 64'hffff_8000_1234_5678);
      check_data("rs2_data_e", rs2_data_e, 64'hffff_ffff_ffff_fff0);
      pc_d  = 48'h7654_3210_abcd;
      imm_d = 32'h0000_0123;
      @(negedge clk);
      check_data("rs1_data_e", rs1_data_e, 64'h0000_7654_3210_abcd);
      check_data("rs2_data_e", rs2_data_e, 64'h0000_0000_0000_0123);
      close_test("rf_other");
   endtask

   task automatic forwarding();
      data_t a;
      data_t b;
      data_t e;
      data_t ld;
      open_test();
      rand_data(a);
      rand_data(b);
      rand_data(e);
      rand_data(ld);
      rd_src        = RD_ALU;
      wb_sel_m      = WB_PIPE;
      alu_rd_data_e = a;
      @(negedge clk);              // m = a
      alu_rd_data_e = b;
      @(negedge clk);              // m = b, w = a
      rs1_sel       = BYP_M;
      rs2_sel       = BYP_W;
      alu_rd_data_e = e;
      load_data_g   = ld;
      @(negedge clk);
      check_data("rs1_data_e", rs1_data_e, b);
      check_data("rs2_data_e", rs2_data_e, a);
      rs1_sel = BYP_E;
      rs2_sel = BYP_LD;
      @(negedge clk);
      check_data("rs1_data_e", rs1_data_e, e);
      check_data("rs2_data_e", rs2_data_e, ld);
      rs1_sel = BYP_LD;
      rs2_sel = BYP_E;
      @(negedge clk);
      check_data("rs1_data_e", rs1_data_e, ld);
      check_data("rs2_data_e", rs2_data_e, e);
      close_test("forwarding");
   endtask

   task automatic pick_rd_source(input byp_pkg::rd_src_e src, input data_t exp);
      rd_src = src;
      @(negedge clk);
      check_data("wsr_data_m", wsr_data_m, exp);
   endtask

   task automatic execute_select();
      data_t y;
      data_t v;
      data_t alu;
      open_test();
      rand_data(y);
      rand_data(v);
      rand_data(alu);
      yreg_e        = y[31:0];
      pr_e          = y[63:56];
      ver_e         = v;
      alu_rd_data_e = alu;
      pick_rd_source(RD_YREG, {32'h0, y[31:0]});
      pick_rd_source(RD_PR, {56'h0, y[63:56]});
      pick_rd_source(RD_VER, v);
      pick_rd_source(RD_ALU, alu);
      close_test("execute");
   endtask

   task automatic writeback();
      data_t p;
      data_t f;
      data_t x;
      data_t r;
      data_t later;
      open_test();
      rand_data(p);
      rand_data(f);
      rand_data(x);
      rand_data(r);
      rand_data(later);
      rd_src        = RD_ALU;
      wb_sel_m      = WB_PIPE;
      alu_rd_data_e = p;
      @(negedge clk);
      alu_rd_data_e = ~p;          // p is in m, only p may reach w
      @(negedge clk);              // two cycles from entry
      check_word("rd_word_w", rd_word_w, with_chk(p));
      load_data_g = f;
      ldxa_g      = 1'b0;
      @(negedge clk);              // g2 = fill data
      wb_sel_m    = WB_LOAD;
      ldxa_data_g = x;
      ldxa_g      = 1'b1;
      @(negedge clk);
      check_word("rd_word_w", rd_word_w, with_chk(f));
      @(negedge clk);
      check_word("rd_word_w", rd_word_w, with_chk(x));
      ldxa_g        = 1'b0;
      wb_sel_m      = WB_PIPE;
      alu_rd_data_e = r;
      @(negedge clk);              // m = r
      restore_m     = 1'b1;
      alu_rd_data_e = later;
      @(negedge clk);
      restore_m     = 1'b0;
      alu_rd_data_e = p;
      @(negedge clk);              // m has moved on twice
      wb_sel_m = WB_RESTORE;
      @(negedge clk);
      check_word("rd_word_w", rd_word_w, with_chk(r));
      wb_sel_m = WB_PIPE;
      close_test("writeback");
   endtask

   task automatic back_to_back();
      data_t v;
      data_t exp;
      int    n;
      open_test();
      rd_src   = RD_ALU;
      wb_sel_m = WB_PIPE;
      pipe_q.delete();
      for (int i = 0; i < 16; i++) begin
         rand_data(v);
         alu_rd_data_e = v;
         pipe_q.push_back(v);
         @(negedge clk);
         if (pipe_q.size() > 1) begin
            exp = pipe_q.pop_front();
            check_word("rd_word_w", rd_word_w, with_chk(exp));
         end
      end
      n = 0;
      while (pipe_q.size() > 0 && n < 4) begin
         @(negedge clk);
         exp = pipe_q.pop_front();
         check_word("rd_word_w", rd_word_w, with_chk(exp));
         n++;
      end
      if (pipe_q.size() != 0) begin
         $display("pipeline values never reached rd_word_w");
         errors++;
      end
      close_test("pipeline");
   endtask

   initial begin
      bit released;
      seed          = 32'hc2b4;
      errors        = 0;
      tests_run     = 0;
      tests_failed  = 0;
      rs1_sel       = BYP_RF;
      rs2_sel       = BYP_RF;
      rf_rs1_data   = '0;
      rf_rs2_data   = '0;
      pc_d          = '0;
      imm_d         = '0;
      alu_rd_data_e = '0;
      rd_src        = RD_YREG;
      yreg_e        = '0;
      pr_e          = '0;
      ver_e         = '0;
      load_data_g   = '0;
      ldxa_data_g   = '0;
      ldxa_g        = 1'b0;
      restore_m     = 1'b0;
      wb_sel_m      = WB_PIPE;
      reset_values();
      wait_reset(released);
      if (!released) begin
         $display("timeout while waiting for rst_n to go high");
         $display("*** TEST FAILED ***");
         $finish;
      end else begin
         rf_and_other();
         forwarding();
         execute_select();
         writeback();
         back_to_back();
         $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
         if (errors == 0) begin
            $display("*** TEST PASSED ***");
         end else begin
            $display("*** TEST FAILED ***");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: filelist.f
source/byp_pkg.sv
source/byp_operand_decode.sv
source/byp_execute.sv
source/byp_result.sv
source/exu_bypass.sv
verif/exu_bypass_sva.sv
verif/tb_exu_bypass.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exu_bypass
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= \*\*\* TEST PASSED \*\*\*

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
